//--- Bender.yml
package:
  name: linproj

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/linproj_data_pkg.sv
      - hdl/linproj_ctrl_pkg.sv
      - hdl/linproj_mem_if.sv
      - hdl/linproj_bram.sv
      - hdl/linproj_ctrl.sv
      - hdl/linproj_block_mac.sv
      - hdl/linproj_accum.sv
      - hdl/linproj_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/tb_linproj.sv

//--- build.f
+incdir+hdl
hdl/linproj_data_pkg.sv
hdl/linproj_ctrl_pkg.sv
hdl/linproj_mem_if.sv
hdl/linproj_bram.sv
hdl/linproj_ctrl.sv
hdl/linproj_block_mac.sv
hdl/linproj_accum.sv
hdl/linproj_top.sv
tests/tb_linproj.sv

//--- hdl/linproj_accum.sv
// ========================================
// Block sum accumulator and C pair output
// ========================================

`timescale 1ns/1ps

module linproj_accum (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    finish,
    input  linproj_data_pkg::psum_t psum0,
    input  linproj_data_pkg::psum_t psum1,
    input  logic                    last,
    output logic                    out_valid,
    output linproj_data_pkg::psum_t out_c0,
    output linproj_data_pkg::psum_t out_c1
);

    linproj_data_pkg::psum_t acc0_q;
    linproj_data_pkg::psum_t acc1_q;
    linproj_data_pkg::psum_t sum0;
    linproj_data_pkg::psum_t sum1;

    // Running sum including the block just finished
    assign sum0 = acc0_q + psum0;
    assign sum1 = acc1_q + psum1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc0_q    <= '0;
            acc1_q    <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            if (finish) begin
                if (last) begin
                    // Pair complete, start the next from zero
                    acc0_q    <= '0;
                    acc1_q    <= '0;
                    out_valid <= 1'b1;
                end else begin
                    acc0_q <= sum0;
                    acc1_q <= sum1;
                end
            end
        end
    end

    // Result held until the next pair
    always_ff @(posedge clk) begin
        if (finish && last) begin
            out_c0 <= sum0;
            out_c1 <= sum1;
        end
    end

endmodule

//--- hdl/linproj_block_mac.sv
// ========================================
// Sequential MAC over one block, two rows
// ========================================

`timescale 1ns/1ps

`include "linproj_defs.svh"

module linproj_block_mac (
    input  logic                    clk,
    input  logic                    rst_n,
    linproj_mem_if.mac              mem,
    output logic                    finish,
    output linproj_data_pkg::psum_t psum0,
    output linproj_data_pkg::psum_t psum1,
    output logic                    last
);

    localparam int IDX_W = $clog2(`LP_BLOCK);

    linproj_data_pkg::block_t a0_q;
    linproj_data_pkg::block_t a1_q;
    linproj_data_pkg::block_t w_q;
    linproj_data_pkg::block_t a0_cur;
    linproj_data_pkg::block_t a1_cur;
    linproj_data_pkg::block_t w_cur;
    linproj_data_pkg::elem_t  a0_e;
    linproj_data_pkg::elem_t  a1_e;
    linproj_data_pkg::elem_t  w_e;
    linproj_data_pkg::psum_t  prod0;
    linproj_data_pkg::psum_t  prod1;
    logic [IDX_W-1:0]         idx_q;
    logic                     running_q;

    // Element 0 comes straight off the read bus
    assign a0_cur = mem.blk_start ? mem.rdata_a : a0_q;
    assign a1_cur = mem.blk_start ? mem.rdata_b : a1_q;
    assign w_cur  = mem.blk_start ? mem.w_rdata : w_q;

    assign a0_e  = a0_cur[idx_q];
    assign a1_e  = a1_cur[idx_q];
    assign w_e   = w_cur[idx_q];
    // Signed, widened to sum width
    assign prod0 = a0_e * w_e;
    assign prod1 = a1_e * w_e;

    // Step counter and finish pulse
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running_q <= 1'b0;
            idx_q     <= '0;
            finish    <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (mem.blk_start) begin
                running_q <= 1'b1;
                idx_q     <= IDX_W'(1);
            end else if (running_q) begin
                if (idx_q == IDX_W'(`LP_BLOCK - 1)) begin
                    running_q <= 1'b0;
                    idx_q     <= '0;
                    finish    <= 1'b1;
                end else begin
                    idx_q <= idx_q + 1'b1;
                end
            end
        end
    end

    // Operand latch and running sums
    always_ff @(posedge clk) begin
        if (mem.blk_start) begin
            a0_q  <= mem.rdata_a;
            a1_q  <= mem.rdata_b;
            w_q   <= mem.w_rdata;
            last  <= mem.last_blk;
            psum0 <= prod0;
            psum1 <= prod1;
        end else if (running_q) begin
            psum0 <= psum0 + prod0;
            psum1 <= psum1 + prod1;
        end
    end

endmodule

//--- hdl/linproj_bram.sv
// ========================================
// Block memory, one write and two reads
// ========================================

`timescale 1ns/1ps

`include "linproj_defs.svh"

module linproj_bram #(
    parameter int DEPTH = `LP_A_WORDS
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  linproj_data_pkg::block_t wdata,
    linproj_mem_if.mem               mem
);

    // W memory is told apart by its depth
    localparam bit W_SIDE = (DEPTH == `LP_W_WORDS);

    linproj_data_pkg::block_t mem_q [DEPTH];

    // Host write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem_q[waddr] <= wdata;
        end
    end

    generate
        if (W_SIDE) begin : g_w_port
            // Single read for the W column block
            always_ff @(posedge clk) begin
                if (!rst_n) begin
                    mem.w_rdata <= '0;
                end else if (mem.rd_en) begin
                    mem.w_rdata <= mem_q[mem.w_addr];
                end
            end
        end else begin : g_a_ports
            // Even row on port A, odd row on port B
            always_ff @(posedge clk) begin
                if (!rst_n) begin
                    mem.rdata_a <= '0;
                    mem.rdata_b <= '0;
                end else if (mem.rd_en) begin
                    mem.rdata_a <= mem_q[mem.addr_a];
                    mem.rdata_b <= mem_q[mem.addr_b];
                end
            end
        end
    endgenerate

endmodule

//--- hdl/linproj_ctrl.sv
// ========================================
// Load/run FSM and block address walk
// ========================================

`timescale 1ns/1ps

`include "linproj_defs.svh"

module linproj_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_we,
    input  logic                      w_we,
    input  linproj_data_pkg::a_addr_t in_addr,
    input  linproj_data_pkg::w_addr_t w_addr,
    input  logic                      finish,
    output logic                      a_we,
    output logic                      w_we_mux,
    output linproj_data_pkg::a_addr_t a_waddr,
    output linproj_data_pkg::w_addr_t w_waddr,
    linproj_mem_if.ctrl               mem,
    output logic                      busy,
    output logic [`LP_PAIR_W-1:0]     out_row_pair,
    output logic [`LP_COL_W-1:0]      out_col,
    output logic                      done
);

    linproj_ctrl_pkg::ctrl_state_t state_q;
    linproj_ctrl_pkg::blk_pos_t    blk_q;
    logic [`LP_COL_W-1:0]          col_q;
    logic [`LP_PAIR_W-1:0]         pair_q;

    logic load_phase;
    logic last_in_row;
    logic last_col;
    logic last_pair;

    assign load_phase  = (state_q == linproj_ctrl_pkg::LOAD);
    assign last_in_row = (blk_q == `LP_KB - 1);
    assign last_col    = (col_q == `LP_COLS_C - 1);
    assign last_pair   = (pair_q == `LP_ROWS_A / 2 - 1);

    // Host writes pass only while loading
    assign a_we     = load_phase & in_we;
    assign w_we_mux = load_phase & w_we;
    assign a_waddr  = in_addr;
    assign w_waddr  = w_addr;

    // Read side, rows 2r and 2r+1 against column c
    assign mem.rd_en  = (state_q == linproj_ctrl_pkg::ISSUE);
    assign mem.addr_a = linproj_data_pkg::a_addr_t'(pair_q * 2 * `LP_KB + blk_q);
    assign mem.addr_b = linproj_data_pkg::a_addr_t'((pair_q * 2 + 1) * `LP_KB + blk_q);
    assign mem.w_addr = linproj_data_pkg::w_addr_t'(col_q * `LP_KB + blk_q);

    assign busy = (state_q != linproj_ctrl_pkg::LOAD) &&
                  (state_q != linproj_ctrl_pkg::FINISHED);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q       <= linproj_ctrl_pkg::LOAD;
            blk_q         <= '0;
            col_q         <= '0;
            pair_q        <= '0;
            done          <= 1'b0;
            mem.blk_start <= 1'b0;
            mem.last_blk  <= 1'b0;
        end else begin
            mem.blk_start <= 1'b0;
            case (state_q)
                linproj_ctrl_pkg::LOAD: begin
                    // Last A word starts the run, W is already in
                    if (in_we && in_addr == linproj_data_pkg::a_addr_t'(`LP_A_WORDS - 1)) begin
                        state_q <= linproj_ctrl_pkg::ISSUE;
                    end
                end
                linproj_ctrl_pkg::ISSUE: begin
                    // Data lands next cycle, flag it for the MAC
                    mem.blk_start <= 1'b1;
                    mem.last_blk  <= last_in_row;
                    state_q       <= linproj_ctrl_pkg::WAIT_BLK;
                end
                linproj_ctrl_pkg::WAIT_BLK: begin
                    if (finish) begin
                        if (last_in_row && last_col && last_pair) begin
                            // Rises with the final out_valid
                            state_q <= linproj_ctrl_pkg::FINISHED;
                            done    <= 1'b1;
                        end else begin
                            state_q <= linproj_ctrl_pkg::NEXT;
                        end
                    end
                end
                linproj_ctrl_pkg::NEXT: begin
                    // Block first, then column, then row pair
                    if (last_in_row) begin
                        blk_q <= '0;
                        if (last_col) begin
                            col_q  <= '0;
                            pair_q <= pair_q + 1'b1;
                        end else begin
                            col_q <= col_q + 1'b1;
                        end
                    end else begin
                        blk_q <= blk_q + 1'b1;
                    end
                    state_q <= linproj_ctrl_pkg::ISSUE;
                end
                linproj_ctrl_pkg::FINISHED: begin
                    // Held until reset
                    state_q <= linproj_ctrl_pkg::FINISHED;
                end
                default: state_q <= linproj_ctrl_pkg::LOAD;
            endcase
        end
    end

    // Position of the pair, lines up with out_valid
    always_ff @(posedge clk) begin
        if (state_q == linproj_ctrl_pkg::WAIT_BLK && finish && last_in_row) begin
            out_row_pair <= pair_q;
            out_col      <= col_q;
        end
    end

endmodule

//--- hdl/linproj_ctrl_pkg.sv
// ========================================
// Controller state and block index types
// ========================================

`include "linproj_defs.svh"

package linproj_ctrl_pkg;

    // Controller FSM states
    typedef enum logic [2:0] {
        LOAD,
        ISSUE,
        WAIT_BLK,
        NEXT,
        FINISHED
    } ctrl_state_t;

    // Block position inside a row
    typedef logic [$clog2(`LP_KB)-1:0] blk_pos_t;

endpackage

//--- hdl/linproj_data_pkg.sv
// ========================================
// Element, block, sum and address types
// ========================================

`include "linproj_defs.svh"

package linproj_data_pkg;

    // One signed matrix element
    typedef logic signed [`LP_DATA_W-1:0] elem_t;

    // One memory word, element 0 in the low bits
    typedef elem_t [`LP_BLOCK-1:0] block_t;

    // Partial and final dot product
    typedef logic signed [`LP_ACC_W-1:0] psum_t;

    // Word addresses, row or column times LP_KB plus block
    typedef logic [$clog2(`LP_A_WORDS)-1:0] a_addr_t;
    typedef logic [$clog2(`LP_W_WORDS)-1:0] w_addr_t;

endpackage

//--- hdl/linproj_defs.svh
// ========================================
// Sizing macros for the projection datapath
// ========================================

`ifndef LINPROJ_DEFS_SVH
`define LINPROJ_DEFS_SVH

// Element width in bits, signed
`define LP_DATA_W 8
// Elements packed into one memory word
`define LP_BLOCK 4
// Inner dimension of the product
`define LP_INNER 8
// Rows of A, kept even so rows go out in pairs
`define LP_ROWS_A 4
// Columns of W and of C
`define LP_COLS_C 2

// Blocks per row of A or column of W
`define LP_KB (`LP_INNER / `LP_BLOCK)
// Memory depths in words
`define LP_A_WORDS (`LP_ROWS_A * `LP_KB)
`define LP_W_WORDS (`LP_COLS_C * `LP_KB)
// Sum width, product width plus headroom
`define LP_ACC_W (2 * `LP_DATA_W + 4)
// Counter widths for the row pair and the column
`define LP_PAIR_W $clog2(`LP_ROWS_A / 2)
`define LP_COL_W $clog2(`LP_COLS_C)

`endif

//--- hdl/linproj_mem_if.sv
// ========================================
// Read bus between FSM, memories and MAC
// ========================================

`timescale 1ns/1ps

interface linproj_mem_if;

    logic                      rd_en;
    linproj_data_pkg::a_addr_t addr_a;
    linproj_data_pkg::a_addr_t addr_b;
    linproj_data_pkg::w_addr_t w_addr;
    linproj_data_pkg::block_t  rdata_a;
    linproj_data_pkg::block_t  rdata_b;
    linproj_data_pkg::block_t  w_rdata;
    // Read data valid this cycle
    logic                      blk_start;
    logic                      last_blk;

    modport ctrl (output rd_en, addr_a, addr_b, w_addr, blk_start, last_blk);
    modport mem  (input rd_en, addr_a, addr_b, w_addr, output rdata_a, rdata_b, w_rdata);
    modport mac  (input rdata_a, rdata_b, w_rdata, blk_start, last_blk);

endinterface

//--- hdl/linproj_top.sv
// ========================================
// Projection accelerator top level
// ========================================

`timescale 1ns/1ps

`include "linproj_defs.svh"

module linproj_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_we,
    input  linproj_data_pkg::a_addr_t in_addr,
    input  linproj_data_pkg::block_t  in_wdata,
    input  logic                      w_we,
    input  linproj_data_pkg::w_addr_t w_addr,
    input  linproj_data_pkg::block_t  w_wdata,
    output logic                      busy,
    output logic                      out_valid,
    output logic [`LP_PAIR_W-1:0]     out_row_pair,
    output logic [`LP_COL_W-1:0]      out_col,
    output linproj_data_pkg::psum_t   out_c0,
    output linproj_data_pkg::psum_t   out_c1,
    output logic                      done
);

    logic                      a_we;
    logic                      w_we_mux;
    linproj_data_pkg::a_addr_t a_waddr;
    linproj_data_pkg::w_addr_t w_waddr;
    logic                      finish;
    linproj_data_pkg::psum_t   psum0;
    linproj_data_pkg::psum_t   psum1;
    logic                      last;

    // Main read bus, and the W memory's own bus
    linproj_mem_if a_bus ();
    linproj_mem_if w_bus ();

    // W bus shares the FSM read request
    assign w_bus.rd_en   = a_bus.rd_en;
    assign w_bus.w_addr  = a_bus.w_addr;
    assign a_bus.w_rdata = w_bus.w_rdata;

    linproj_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_we        (in_we),
        .w_we         (w_we),
        .in_addr      (in_addr),
        .w_addr       (w_addr),
        .finish       (finish),
        .a_we         (a_we),
        .w_we_mux     (w_we_mux),
        .a_waddr      (a_waddr),
        .w_waddr      (w_waddr),
        .mem          (a_bus.ctrl),
        .busy         (busy),
        .out_row_pair (out_row_pair),
        .out_col      (out_col),
        .done         (done)
    );

    linproj_bram #(.DEPTH(`LP_A_WORDS)) u_a_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (a_we),
        .waddr (a_waddr),
        .wdata (in_wdata),
        .mem   (a_bus.mem)
    );

    linproj_bram #(.DEPTH(`LP_W_WORDS)) u_w_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (w_we_mux),
        .waddr (w_waddr),
        .wdata (w_wdata),
        .mem   (w_bus.mem)
    );

    linproj_block_mac u_mac (
        .clk    (clk),
        .rst_n  (rst_n),
        .mem    (a_bus.mac),
        .finish (finish),
        .psum0  (psum0),
        .psum1  (psum1),
        .last   (last)
    );

    linproj_accum u_accum (
        .clk       (clk),
        .rst_n     (rst_n),
        .finish    (finish),
        .psum0     (psum0),
        .psum1     (psum1),
        .last      (last),
        .out_valid (out_valid),
        .out_c0    (out_c0),
        .out_c1    (out_c1)
    );

endmodule

//--- tests/tb_linproj.sv
// ========================================
// Testbench for the projection accelerator
// ========================================

`timescale 1ns/1ps

`include "linproj_defs.svh"

module tb_linproj;

    localparam int NUM_PAIRS = `LP_ROWS_A / 2 * `LP_COLS_C;
    // 3 runs of 10 reset + 24 load + 8 blocks of 7 cycles + 50 hold, wide margin
    localparam int CYCLE_LIMIT = 2000;

    logic                      clk;
    logic                      rst_n;
    logic                      in_we;
    linproj_data_pkg::a_addr_t in_addr;
    linproj_data_pkg::block_t  in_wdata;
    logic                      w_we;
    linproj_data_pkg::w_addr_t w_addr;
    linproj_data_pkg::block_t  w_wdata;
    logic                      busy;
    logic                      out_valid;
    logic [`LP_PAIR_W-1:0]     out_row_pair;
    logic [`LP_COL_W-1:0]      out_col;
    linproj_data_pkg::psum_t   out_c0;
    linproj_data_pkg::psum_t   out_c1;
    logic                      done;

    // Host copy of both matrices, source of the expected values
    int          a_mat [`LP_ROWS_A][`LP_INNER];
    int          w_mat [`LP_INNER][`LP_COLS_C];
    logic [15:0] lfsr_q;
    int          pair_cnt;
    int          pass_cnt;
    int          fail_cnt;
    int          cycle_cnt;
    int          test_errs [1:6];
    // Test numbers that own each kind of check in the current run
    int          idle_test;
    int          val_test;
    int          ord_test;
    int          done_test;

    linproj_top UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_we        (in_we),
        .in_addr      (in_addr),
        .in_wdata     (in_wdata),
        .w_we         (w_we),
        .w_addr       (w_addr),
        .w_wdata      (w_wdata),
        .busy         (busy),
        .out_valid    (out_valid),
        .out_row_pair (out_row_pair),
        .out_col      (out_col),
        .out_c0       (out_c0),
        .out_c1       (out_c1),
        .done         (done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // 16-bit Galois LFSR, taps 16,14,13,11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One signed element, one LFSR step per bit
    task automatic draw_elem(output int v);
        logic [7:0] bits;
        for (int i = 0; i < 8; i++) begin
            bits[i] = lfsr_q[0];
            lfsr_q  = lfsr_next(lfsr_q);
        end
        v = int'($signed(bits));
    endtask

    // Expected C element, plain signed dot product
    function automatic longint ref_c(input int row, input int col);
        longint acc;
        acc = 0;
        for (int k = 0; k < `LP_INNER; k++) begin
            acc += longint'(a_mat[row][k]) * longint'(w_mat[k][col]);
        end
        return acc;
    endfunction

    // Word layout, element 0 is the lowest inner index
    function automatic linproj_data_pkg::block_t a_word(input int addr);
        linproj_data_pkg::block_t blk;
        for (int e = 0; e < `LP_BLOCK; e++) begin
            blk[e] = linproj_data_pkg::elem_t'(
                a_mat[addr / `LP_KB][(addr % `LP_KB) * `LP_BLOCK + e]);
        end
        return blk;
    endfunction

    function automatic linproj_data_pkg::block_t w_word(input int addr);
        linproj_data_pkg::block_t blk;
        for (int e = 0; e < `LP_BLOCK; e++) begin
            blk[e] = linproj_data_pkg::elem_t'(
                w_mat[(addr % `LP_KB) * `LP_BLOCK + e][addr / `LP_KB]);
        end
        return blk;
    endfunction

    task automatic check_value(input int test, input string name, input longint exp,
                               input longint act);
        assert (exp == act) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
            test_errs[test]++;
            $display("FAIL at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_true(input int test, input bit cond, input string what);
        assert (cond) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
            test_errs[test]++;
            $display("Error at %0t: %s", $time, what);
        end
    endtask

    task automatic report_test(input int test, input string name);
        if (test_errs[test] == 0) begin
            $display("Test %0d %s: ok", test, name);
        end else begin
            $display("Test %0d %s: %0d errors", test, name, test_errs[test]);
        end
    endtask

    // Which test each kind of check counts toward
    task automatic route_checks(input int idle, input int val, input int ord, input int dn);
        idle_test = idle;
        val_test  = val;
        ord_test  = ord;
        done_test = dn;
    endtask

    task automatic write_a(input int addr, input linproj_data_pkg::block_t data);
        @(posedge clk);
        in_we    <= 1'b1;
        in_addr  <= linproj_data_pkg::a_addr_t'(addr);
        in_wdata <= data;
        @(posedge clk);
        in_we <= 1'b0;
    endtask

    task automatic write_w(input int addr, input linproj_data_pkg::block_t data);
        @(posedge clk);
        w_we    <= 1'b1;
        w_addr  <= linproj_data_pkg::w_addr_t'(addr);
        w_wdata <= data;
        @(posedge clk);
        w_we <= 1'b0;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        in_we <= 1'b0;
        w_we  <= 1'b0;
        repeat (10) @(posedge clk);
        pair_cnt = 0;
        rst_n <= 1'b1;
        @(negedge clk);
        check_value(idle_test, "out_valid", 0, out_valid);
        check_value(idle_test, "done", 0, done);
        check_value(idle_test, "busy", 0, busy);
    endtask

    // W first, then A, the last A word starts the run
    task automatic load_and_run(input bit late_writes);
        linproj_data_pkg::block_t junk;
        int v;
        for (int i = 0; i < `LP_W_WORDS; i++) begin
            write_w(i, w_word(i));
        end
        for (int i = 0; i < `LP_A_WORDS; i++) begin
            write_a(i, a_word(i));
            if (i < `LP_A_WORDS - 1) begin
                @(negedge clk);
                check_value(idle_test, "busy", 0, busy);
                check_value(idle_test, "done", 0, done);
                check_value(idle_test, "out_valid", 0, out_valid);
            end
        end
        @(negedge clk);
        check_true(idle_test, busy, "busy did not rise after the last A write");
        // Junk writes during the run, host copy stays as loaded
        if (late_writes) begin
            for (int i = 0; i < `LP_A_WORDS + `LP_W_WORDS; i++) begin
                for (int e = 0; e < `LP_BLOCK; e++) begin
                    draw_elem(v);
                    junk[e] = linproj_data_pkg::elem_t'(v);
                end
                if (i < `LP_A_WORDS) write_a(i, junk);
                else write_w(i - `LP_A_WORDS, junk);
            end
        end
        while (!done) @(negedge clk);
    endtask

    task automatic hold_after_done();
        repeat (50) begin
            @(negedge clk);
            check_true(done_test, done, "done dropped before reset");
        end
        check_true(ord_test, pair_cnt == NUM_PAIRS,
                   $sformatf("expected %0d pairs, saw %0d", NUM_PAIRS, pair_cnt));
    endtask

    // Compares every pair, also flags pairs past the last one
    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            if (pair_cnt >= NUM_PAIRS) begin
                check_true(done_test, 1'b0,
                           "an extra out_valid pulse came after the last pair");
            end else begin
                check_value(ord_test, "out_row_pair", pair_cnt / `LP_COLS_C, out_row_pair);
                check_value(ord_test, "out_col", pair_cnt % `LP_COLS_C, out_col);
                check_value(val_test, "out_c0", ref_c(2 * out_row_pair, out_col), out_c0);
                check_value(val_test, "out_c1", ref_c(2 * out_row_pair + 1, out_col), out_c1);
                check_value(done_test, "done", pair_cnt == NUM_PAIRS - 1, done);
            end
            pair_cnt++;
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        rst_n    = 1'b0;
        in_we    = 1'b0;
        in_addr  = '0;
        in_wdata = '0;
        w_we     = 1'b0;
        w_addr   = '0;
        w_wdata  = '0;
        lfsr_q   = 16'd77;
        pair_cnt = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        foreach (test_errs[t]) test_errs[t] = 0;
        foreach (a_mat[r, k]) draw_elem(a_mat[r][k]);
        foreach (w_mat[k, c]) draw_elem(w_mat[k][c]);

        route_checks(1, 2, 3, 4);
        apply_reset();
        load_and_run(1'b0);
        report_test(1, "idle outputs through reset and load");
        report_test(2, "random pairs against reference");
        hold_after_done();
        report_test(3, "pair order and count");
        report_test(4, "done held, no extra pairs");

        // New data, then junk writes while running
        foreach (a_mat[r, k]) draw_elem(a_mat[r][k]);
        foreach (w_mat[k, c]) draw_elem(w_mat[k][c]);
        route_checks(5, 5, 5, 5);
        apply_reset();
        load_and_run(1'b1);
        hold_after_done();
        report_test(5, "writes during the run ignored");

        // Rows 0,1 at -128 and rows 2,3 at +127, W column 0 low, column 1 high
        foreach (a_mat[r, k]) a_mat[r][k] = (r < 2) ? -128 : 127;
        foreach (w_mat[k, c]) w_mat[k][c] = (c == 0) ? -128 : 127;
        route_checks(6, 6, 6, 6);
        apply_reset();
        load_and_run(1'b0);
        hold_after_done();
        report_test(6, "extreme values");

        $display("Checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
